// File: verilog/i2c_pkg.sv
package i2c_pkg;

    // Host command opcodes
    typedef enum logic [2:0] {
        cmd_start,
        cmd_write,
        cmd_read_ack,
        cmd_read_nack,
        cmd_stop
    } cmd_op_t;

    // Address, data and read result bytes
    typedef logic [7:0] i2c_byte_t;

    typedef logic [3:0] credit_cnt_t;

    // Bus view kept by the monitor
    typedef enum logic [2:0] {
        bus_idle,
        bus_start,
        bus_data,
        bus_ack,
        bus_stop
    } bus_state_t;

    // Quarters of one SCL period, mid-low sits between the two low quarters
    typedef logic [1:0] scl_phase_t;

    localparam scl_phase_t low_first   = 2'd0;
    localparam scl_phase_t low_second  = 2'd1;
    localparam scl_phase_t high_first  = 2'd2;
    localparam scl_phase_t high_second = 2'd3;

endpackage

// File: verilog/i2c_scl_gen.sv
`timescale 1ns/100ps

module i2c_scl_gen import i2c_pkg::*; #(
    parameter int QUARTER_DIV = 4
) (
    input  logic       i2c_vif,
    input  logic       arstn,
    input  logic       scl_run,
    output logic       scl,
    output logic       tick,
    output scl_phase_t phase
);

    localparam int DIV_W = (QUARTER_DIV > 1) ? $clog2(QUARTER_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(QUARTER_DIV - 1);

    logic [DIV_W-1:0] div_cnt;

    // Tick marks the last cycle of the current quarter
    assign tick = scl_run && (div_cnt == DIV_LAST);
    assign scl  = (phase != low_first) && (phase != low_second);

    always_ff @(posedge i2c_vif or negedge arstn) begin
        if (!arstn) begin
            div_cnt <= '0;
        end else if (!scl_run || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge i2c_vif or negedge arstn) begin
        if (!arstn) begin
            phase <= high_first;
        end else if (tick) begin
            phase <= phase + 2'd1;
        end else if (!scl_run && phase == high_second) begin
            // Parked high after a stop, same level so the next start
            // still gets a full high quarter before SDA falls
            phase <= high_first;
        end
    end

endmodule

// File: verilog/i2c_cmd_queue.sv
`timescale 1ns/100ps

module i2c_cmd_queue import i2c_pkg::*; #(
    parameter int CMD_DEPTH = 4
) (
    input  logic      i2c_vif,
    input  logic      arstn,
    input  logic      cmd_valid,
    input  cmd_op_t   cmd_op,
    input  i2c_byte_t cmd_data,
    input  logic      rsp_credit,
    input  logic      cmd_take,
    input  logic      done,
    input  i2c_byte_t result_data,
    input  logic      result_ack,
    output logic      cmd_credit,
    output logic      cmd_avail,
    output cmd_op_t   op,
    output i2c_byte_t data,
    output logic      rsp_valid,
    output i2c_byte_t rsp_data,
    output logic      rsp_ack
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(CMD_DEPTH - 1);

    cmd_op_t          op_mem   [CMD_DEPTH];
    i2c_byte_t        data_mem [CMD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    credit_cnt_t      rsp_cred;

    // Hand over only when the host has room for the answer
    assign cmd_avail = (count != '0) && (rsp_cred != '0);
    assign op        = op_mem[rd_ptr];
    assign data      = data_mem[rd_ptr];

    always_ff @(posedge i2c_vif) begin
        if (cmd_valid) begin
            op_mem[wr_ptr]   <= cmd_op;
            data_mem[wr_ptr] <= cmd_data;
        end
    end

    always_ff @(posedge i2c_vif or negedge arstn) begin
        if (!arstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (cmd_take) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({cmd_valid, cmd_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Response credits granted by the host, one spent per command
    always_ff @(posedge i2c_vif or negedge arstn) begin
        if (!arstn) begin
            rsp_cred <= '0;
        end else begin
            case ({rsp_credit, cmd_take})
                2'b10:   rsp_cred <= rsp_cred + 1'b1;
                2'b01:   rsp_cred <= rsp_cred - 1'b1;
                default: rsp_cred <= rsp_cred;
            endcase
        end
    end

    always_ff @(posedge i2c_vif or negedge arstn) begin
        if (!arstn) begin
            cmd_credit <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            cmd_credit <= cmd_take;
            rsp_valid  <= done;
        end
    end

    always_ff @(posedge i2c_vif) begin
        if (done) begin
            rsp_data <= result_data;
            rsp_ack  <= result_ack;
        end
    end

endmodule

// File: verilog/i2c_byte_engine.sv
`timescale 1ns/100ps

module i2c_byte_engine import i2c_pkg::*; (
    input  logic       i2c_vif,
    input  logic       arstn,
    input  logic       cmd_avail,
    input  cmd_op_t    op,
    input  i2c_byte_t  data,
    input  logic       tick,
    input  scl_phase_t phase,
    input  logic       sda_in,
    output logic       cmd_take,
    output logic       done,
    output i2c_byte_t  result_data,
    output logic       result_ack,
    output logic       scl_run,
    output logic       sda_oe
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_shift,
        st_ack,
        st_stop
    } eng_state_t;

    eng_state_t state;
    cmd_op_t    cur_op;
    i2c_byte_t  shreg;
    logic [2:0] bit_cnt;
    logic       frame_open;
    logic       is_read;
    logic       end_lf;
    logic       end_hf;
    logic       end_hs;
    logic       stop_now;

    assign cmd_take = (state == st_idle) && cmd_avail;
    assign scl_run  = (state != st_idle);
    assign is_read  = (cur_op == cmd_read_ack) || (cur_op == cmd_read_nack);

    // Quarter boundaries: mid-low, mid-high, falling SCL
    assign end_lf = tick && (phase == low_first);
    assign end_hf = tick && (phase == high_first);
    assign end_hs = tick && (phase == high_second);

    // Stop outside a frame is answered at once with no bus activity
    assign stop_now = (state == st_stop && end_hf) ||
                      (cmd_take && op == cmd_stop && !frame_open);

    always_ff @(posedge i2c_vif) begin
        if (cmd_take) begin
            cur_op <= op;
            shreg  <= data;
        end else if (state == st_shift && end_hf) begin
            // Loops back the sent bit on writes
            shreg <= {shreg[6:0], sda_in};
        end

        if (stop_now) begin
            result_data <= '0;
            result_ack  <= 1'b0;
        end else if (state == st_ack) begin
            if (end_hf) begin
                if (cur_op == cmd_read_ack) begin
                    result_ack <= 1'b0;
                end else if (cur_op == cmd_read_nack) begin
                    result_ack <= 1'b1;
                end else begin
                    result_ack <= sda_in;
                end
            end
            if (end_hs) begin
                result_data <= shreg;
            end
        end
    end

    always_ff @(posedge i2c_vif or negedge arstn) begin
        if (!arstn) begin
            state      <= st_idle;
            frame_open <= 1'b0;
            bit_cnt    <= '0;
            sda_oe     <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= stop_now;
            case (state)
                st_idle: begin
                    if (cmd_take) begin
                        bit_cnt <= '0;
                        case (op)
                            cmd_start: state <= st_start;
                            cmd_stop:  state <= frame_open ? st_stop : st_idle;
                            default:   state <= st_shift;
                        endcase
                    end
                end
                st_start: begin
                    // Inside a frame SDA goes high first, giving a repeated start
                    if (end_lf) begin
                        sda_oe <= 1'b0;
                    end
                    if (end_hf) begin
                        sda_oe <= 1'b1;
                    end
                    if (end_hs) begin
                        frame_open <= 1'b1;
                        state      <= st_shift;
                    end
                end
                st_shift: begin
                    if (end_lf) begin
                        sda_oe <= is_read ? 1'b0 : ~shreg[7];
                    end
                    if (end_hs) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_ack;
                        end
                    end
                end
                st_ack: begin
                    // Master pulls low only for a read with ACK
                    if (end_lf) begin
                        sda_oe <= (cur_op == cmd_read_ack);
                    end
                    if (end_hs) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                end
                st_stop: begin
                    if (end_lf) begin
                        sda_oe <= 1'b1;
                    end
                    if (end_hf) begin
                        sda_oe     <= 1'b0;
                        frame_open <= 1'b0;
                        state      <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: verilog/i2c_bus_monitor.sv
`timescale 1ns/100ps

module i2c_bus_monitor import i2c_pkg::*; (
    input  logic      i2c_vif,
    input  logic      arstn,
    input  logic      scl,
    input  logic      sda,
    output i2c_byte_t start_count,
    output i2c_byte_t stop_count,
    output logic      proto_err
);

    bus_state_t state;
    logic       scl_q;
    logic       sda_q;
    logic [2:0] bit_cnt;
    logic       scl_rise;
    logic       scl_fall;
    logic       sda_moved;
    logic       start_det;
    logic       stop_det;
    logic       bad_event;

    assign scl_rise  = !scl_q && scl;
    assign scl_fall  = scl_q && !scl;
    assign sda_moved = scl_q && scl && (sda_q != sda);
    assign start_det = sda_moved && !sda;
    assign stop_det  = sda_moved && sda;

    always_comb begin
        case (state)
            bus_idle:  bad_event = stop_det || (!start_det && !(scl && sda));
            bus_start,
            bus_data,
            bus_ack:   bad_event = sda_moved;
            default:   bad_event = 1'b0;
        endcase
    end

    always_ff @(posedge i2c_vif or negedge arstn) begin
        if (!arstn) begin
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            state       <= bus_idle;
            bit_cnt     <= '0;
            start_count <= '0;
            stop_count  <= '0;
            proto_err   <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (bad_event) begin
                proto_err <= 1'b1;
            end
            case (state)
                bus_idle: begin
                    if (start_det) begin
                        start_count <= start_count + 8'd1;
                        state       <= bus_start;
                    end
                end
                bus_start: begin
                    if (scl_fall) begin
                        bit_cnt <= '0;
                        state   <= bus_data;
                    end
                end
                bus_data: begin
                    if (scl_rise) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= bus_ack;
                        end
                    end
                end
                bus_ack: begin
                    if (scl_rise) begin
                        bit_cnt <= '0;
                        state   <= bus_stop;
                    end
                end
                bus_stop: begin
                    // After the ACK clock a high SCL may carry a start, a stop or bit 7
                    if (start_det) begin
                        start_count <= start_count + 8'd1;
                        state       <= bus_start;
                    end else if (stop_det) begin
                        stop_count <= stop_count + 8'd1;
                        state      <= bus_idle;
                    end else if (scl_rise) begin
                        bit_cnt <= 3'd1;
                    end else if (scl_fall && bit_cnt != '0) begin
                        state <= bus_data;
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

endmodule

// File: verilog/i2c_master_top.sv
`timescale 1ns/100ps

module i2c_master_top import i2c_pkg::*; #(
    parameter int QUARTER_DIV = 4,
    parameter int CMD_DEPTH   = 4
) (
    input  logic      i2c_vif,
    input  logic      arstn,
    input  logic      cmd_valid,
    input  cmd_op_t   cmd_op,
    input  i2c_byte_t cmd_data,
    output logic      cmd_credit,
    input  logic      rsp_credit,
    output logic      rsp_valid,
    output i2c_byte_t rsp_data,
    output logic      rsp_ack,
    output logic      scl,
    output logic      sda_oe,
    input  logic      sda_in,
    output i2c_byte_t start_count,
    output i2c_byte_t stop_count,
    output logic      proto_err
);

    logic       cmd_avail;
    logic       cmd_take;
    cmd_op_t    op;
    i2c_byte_t  data;
    logic       done;
    i2c_byte_t  result_data;
    logic       result_ack;
    logic       scl_run;
    logic       tick;
    scl_phase_t phase;

    i2c_scl_gen #(
        .QUARTER_DIV(QUARTER_DIV)
    ) scl_gen0 (
        .i2c_vif(i2c_vif),
        .arstn  (arstn),
        .scl_run(scl_run),
        .scl    (scl),
        .tick   (tick),
        .phase  (phase)
    );

    i2c_cmd_queue #(
        .CMD_DEPTH(CMD_DEPTH)
    ) cmd_queue0 (
        .i2c_vif    (i2c_vif),
        .arstn      (arstn),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .rsp_credit (rsp_credit),
        .cmd_take   (cmd_take),
        .done       (done),
        .result_data(result_data),
        .result_ack (result_ack),
        .cmd_credit (cmd_credit),
        .cmd_avail  (cmd_avail),
        .op         (op),
        .data       (data),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_ack    (rsp_ack)
    );

    i2c_byte_engine byte_engine0 (
        .i2c_vif    (i2c_vif),
        .arstn      (arstn),
        .cmd_avail  (cmd_avail),
        .op         (op),
        .data       (data),
        .tick       (tick),
        .phase      (phase),
        .sda_in     (sda_in),
        .cmd_take   (cmd_take),
        .done       (done),
        .result_data(result_data),
        .result_ack (result_ack),
        .scl_run    (scl_run),
        .sda_oe     (sda_oe)
    );

    // Watches the resolved bus, not the master's own drive
    i2c_bus_monitor bus_monitor0 (
        .i2c_vif    (i2c_vif),
        .arstn      (arstn),
        .scl        (scl),
        .sda        (sda_in),
        .start_count(start_count),
        .stop_count (stop_count),
        .proto_err  (proto_err)
    );

endmodule

// File: verification/i2c_slave_model.sv
`timescale 1ns/100ps

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h2A
) (
    input  logic scl,
    input  logic sda,
    output logic pull
);

    typedef enum logic [2:0] {
        sl_idle,
        sl_addr,
        sl_write,
        sl_read,
        sl_ignore
    } slave_mode_t;

    slave_mode_t mode = sl_idle;
    logic [7:0]  mem [16];
    logic [7:0]  rx = 8'h00;
    logic [7:0]  tx = 8'h00;
    logic        drive_low = 1'b0;
    logic        scl_p = 1'b1;
    logic        sda_p = 1'b1;
    int          bitn = 0;
    int          wr_idx = 0;
    int          rd_idx = 0;

    assign pull = drive_low;

    always @(scl or sda) begin
        if (scl && scl_p && sda != sda_p) begin
            // Start or stop, depending on the SDA direction
            mode = sda ? sl_idle : sl_addr;
            bitn = 0;
            drive_low = 1'b0;
        end else if (scl && !scl_p) begin
            if (bitn < 8) begin
                rx = {rx[6:0], sda};
            end else if (mode == sl_read && sda) begin
                // Master NACK ends the read burst
                mode = sl_ignore;
            end
            bitn = bitn + 1;
        end else if (!scl && scl_p) begin
            if (bitn == 8) begin
                case (mode)
                    sl_addr: begin
                        if (rx[7:1] == ADDR) begin
                            drive_low = 1'b1;
                            if (rx[0]) begin
                                mode = sl_read;
                                rd_idx = 0;
                            end else begin
                                mode = sl_write;
                                wr_idx = 0;
                            end
                        end else begin
                            mode = sl_ignore;
                        end
                    end
                    sl_write: begin
                        mem[wr_idx[3:0]] = rx;
                        wr_idx = wr_idx + 1;
                        drive_low = 1'b1;
                    end
                    default: drive_low = 1'b0;
                endcase
            end else if (bitn == 9) begin
                bitn = 0;
                drive_low = 1'b0;
                if (mode == sl_read) begin
                    tx = mem[rd_idx[3:0]];
                    rd_idx = rd_idx + 1;
                    drive_low = !tx[7];
                end
            end else if (mode == sl_read && bitn > 0) begin
                drive_low = !tx[3'(7 - bitn)];
            end
        end
        scl_p = scl;
        sda_p = sda;
    end

endmodule

// File: verification/i2c_tb.sv
`timescale 1ns/100ps

module i2c_tb import i2c_pkg::*; ;

    localparam int QDIV = 4;
    localparam int CMD_DEPTH = 4;
    localparam int SCL_CYCLES = 4 * QDIV;
    localparam int NUM_CMDS = 20;
    // Ten SCL periods per command, plus the fixed idle waits of the credit test
    localparam int WATCHDOG_NS = (NUM_CMDS * 10 + 80) * SCL_CYCLES * 20 + 2000;

    logic      i2c_vif = 1'b0;
    logic      arstn;
    logic      cmd_valid;
    cmd_op_t   cmd_op;
    i2c_byte_t cmd_data;
    logic      cmd_credit;
    logic      rsp_credit;
    logic      rsp_valid;
    i2c_byte_t rsp_data;
    logic      rsp_ack;
    logic      scl;
    logic      sda_oe;
    logic      sda;
    logic      slave_pull;
    i2c_byte_t start_count;
    i2c_byte_t stop_count;
    logic      proto_err;

    int        errors = 0;
    int        checks = 0;
    int        issued = 0;
    int        credits_back = 0;
    int        rsp_total = 0;
    int        starts = 0;
    int        stops = 0;
    i2c_byte_t rsp_d_q [$];
    i2c_byte_t rsp_a_q [$];
    i2c_byte_t wr_bytes [4];
    int        base;

    // Wired-AND with pull-up
    assign sda = !(sda_oe || slave_pull);

    always #10 i2c_vif = ~i2c_vif;

    i2c_master_top #(
        .QUARTER_DIV(QDIV),
        .CMD_DEPTH  (CMD_DEPTH)
    ) dut0 (
        .i2c_vif    (i2c_vif),
        .arstn      (arstn),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .cmd_credit (cmd_credit),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_ack    (rsp_ack),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda),
        .start_count(start_count),
        .stop_count (stop_count),
        .proto_err  (proto_err)
    );

    i2c_slave_model #(
        .ADDR(7'h2A)
    ) slave0 (
        .scl (scl),
        .sda (sda),
        .pull(slave_pull)
    );

    // Response capture and command credit return
    always @(posedge i2c_vif) begin
        if (rsp_valid) begin
            rsp_d_q.push_back(rsp_data);
            rsp_a_q.push_back(i2c_byte_t'(rsp_ack));
            rsp_total = rsp_total + 1;
        end
        if (cmd_credit) begin
            credits_back = credits_back + 1;
        end
        // At most one credit comes back per accepted command
        assert (credits_back <= issued) else begin
            errors = errors + 1;
            $display("cmd_credit returned %0d credits for only %0d commands",
                     credits_back, issued);
        end
    end

    task automatic check_value(input string name, input i2c_byte_t got, input i2c_byte_t exp);
        checks = checks + 1;
        assert (got === exp) else begin
            errors = errors + 1;
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic grant_credit();
        @(posedge i2c_vif);
        #2;
        rsp_credit = 1'b1;
        @(posedge i2c_vif);
        #2;
        rsp_credit = 1'b0;
    endtask

    // Spends one command credit, optionally granting response space too
    task automatic issue(input cmd_op_t op, input i2c_byte_t val, input logic grant);
        @(posedge i2c_vif);
        #2;
        while (issued - credits_back >= CMD_DEPTH) begin
            @(posedge i2c_vif);
            #2;
        end
        cmd_valid = 1'b1;
        cmd_op = op;
        cmd_data = val;
        rsp_credit = grant;
        issued = issued + 1;
        if (op == cmd_start) begin
            starts = starts + 1;
        end
        if (op == cmd_stop) begin
            stops = stops + 1;
        end
        @(posedge i2c_vif);
        #2;
        cmd_valid = 1'b0;
        rsp_credit = 1'b0;
    endtask

    task automatic wait_responses(input int n);
        int limit;
        limit = n * 10 * SCL_CYCLES + 100;
        while (rsp_d_q.size() < n && limit > 0) begin
            @(posedge i2c_vif);
            limit = limit - 1;
        end
        if (rsp_d_q.size() < n) begin
            errors = errors + 1;
            $display("timed out waiting for %0d responses, got %0d", n, rsp_d_q.size());
        end
    endtask

    task automatic check_rsp(input i2c_byte_t exp_data, input i2c_byte_t exp_ack);
        if (rsp_d_q.size() == 0) begin
            errors = errors + 1;
            $display("expected response is missing");
        end else begin
            check_value("rsp_data", rsp_d_q.pop_front(), exp_data);
            check_value("rsp_ack", rsp_a_q.pop_front(), exp_ack);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, run did not complete", $time);
        $display("checks: %0d errors: %0d", checks, errors + 1);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        base = $urandom(3940);
        arstn = 1'b0;
        cmd_valid = 1'b0;
        cmd_op = cmd_start;
        cmd_data = '0;
        rsp_credit = 1'b0;
        repeat (4) @(posedge i2c_vif);
        #2;
        arstn = 1'b1;

        // Write frame
        for (int i = 0; i < 4; i++) begin
            wr_bytes[i] = i2c_byte_t'($urandom);
        end
        issue(cmd_start, 8'h54, 1'b1);
        for (int i = 0; i < 4; i++) begin
            issue(cmd_write, wr_bytes[i], 1'b1);
        end
        issue(cmd_stop, 8'h00, 1'b1);
        wait_responses(6);
        check_rsp(8'h54, 8'h00);
        for (int i = 0; i < 4; i++) begin
            check_rsp(wr_bytes[i], 8'h00);
            check_value("slave mem", slave0.mem[i], wr_bytes[i]);
        end
        check_rsp(8'h00, 8'h00);

        // Read-back through a repeated start
        for (int i = 0; i < 3; i++) begin
            wr_bytes[i] = i2c_byte_t'($urandom);
        end
        issue(cmd_start, 8'h54, 1'b1);
        for (int i = 0; i < 3; i++) begin
            issue(cmd_write, wr_bytes[i], 1'b1);
        end
        issue(cmd_start, 8'h55, 1'b1);
        issue(cmd_read_ack, 8'hff, 1'b1);
        issue(cmd_read_ack, 8'hff, 1'b1);
        issue(cmd_read_nack, 8'hff, 1'b1);
        issue(cmd_stop, 8'h00, 1'b1);
        wait_responses(9);
        check_rsp(8'h54, 8'h00);
        for (int i = 0; i < 3; i++) begin
            check_rsp(wr_bytes[i], 8'h00);
        end
        check_rsp(8'h55, 8'h00);
        check_rsp(wr_bytes[0], 8'h00);
        check_rsp(wr_bytes[1], 8'h00);
        check_rsp(wr_bytes[2], 8'h01);
        check_rsp(8'h00, 8'h00);

        // No slave answers at 0x20
        issue(cmd_start, 8'h40, 1'b1);
        issue(cmd_stop, 8'h00, 1'b1);
        wait_responses(2);
        check_rsp(8'h40, 8'h01);
        check_rsp(8'h00, 8'h00);
        repeat (4) @(posedge i2c_vif);
        check_value("bus scl/sda", i2c_byte_t'({scl, sda}), 8'h03);

        // Responses held back until the host grants space
        wr_bytes[0] = i2c_byte_t'($urandom);
        base = rsp_total;
        issue(cmd_start, 8'h54, 1'b0);
        issue(cmd_write, wr_bytes[0], 1'b0);
        issue(cmd_stop, 8'h00, 1'b0);
        repeat (20 * SCL_CYCLES) @(posedge i2c_vif);
        check_value("rsp count without credit", i2c_byte_t'(rsp_total - base), 8'h00);
        check_value("idle bus scl/sda", i2c_byte_t'({scl, sda}), 8'h03);
        grant_credit();
        wait_responses(1);
        repeat (12 * SCL_CYCLES) @(posedge i2c_vif);
        check_value("rsp count after one grant", i2c_byte_t'(rsp_total - base), 8'h01);
        grant_credit();
        grant_credit();
        wait_responses(3);
        check_rsp(8'h54, 8'h00);
        check_rsp(wr_bytes[0], 8'h00);
        check_rsp(8'h00, 8'h00);

        repeat (4) @(posedge i2c_vif);
        check_value("cmd_credit pulses", i2c_byte_t'(credits_back), i2c_byte_t'(issued));
        check_value("start_count", start_count, i2c_byte_t'(starts));
        check_value("stop_count", stop_count, i2c_byte_t'(stops));
        check_value("proto_err", i2c_byte_t'(proto_err), 8'h00);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/i2c_pkg.sv
verilog/i2c_scl_gen.sv
verilog/i2c_cmd_queue.sv
verilog/i2c_byte_engine.sv
verilog/i2c_bus_monitor.sv
verilog/i2c_master_top.sv
verification/i2c_slave_model.sv
verification/i2c_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the I2C master testbench with Verilator
rm -f sim.log
verilator --binary --timing -f list.f --top-module i2c_tb -o i2c_sim > build.log 2>&1 &&
./obj_dir/i2c_sim > sim.log 2>&1 ||
echo "build or simulation step failed, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
